// File: rtl/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS); // word index bits of the data memory.

    localparam logic [XLEN-1:0] EXIT_PC = 32'hffff_ff00;

    typedef logic [7:0] inst_id_t;
    localparam inst_id_t IID_NONE = 8'hff; // never issued, so the first real id always counts.

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC,
        WB_CSR
    } wb_sel_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_RW,
        CSR_RS,
        CSR_RC
    } csr_op_e;

    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_CYCLE    = 12'hC00;
    localparam logic [11:0] CSR_INSTRET  = 12'hC02;

    typedef struct packed {
        wb_sel_e     wb_sel;
        logic        rf_wen;
        logic [4:0]  wb_addr;
        mem_op_e     mem_op;
        csr_op_e     csr_op;
        logic [11:0] csr_addr;
    } ctrl_t;

    // operand is the store data or the CSR source value.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_id_t        inst_id;
        ctrl_t           ctrl;
        logic [XLEN-1:0] alu_out;
        logic [XLEN-1:0] operand;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_id_t        inst_id;
        ctrl_t           ctrl;
        logic [XLEN-1:0] alu_out;
        logic [XLEN-1:0] csr_rdata;
    } wb_req_t;

endpackage

// File: rtl/data_memory.sv
module data_memory
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            en_i,
    input  mem_op_e         op_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rdata_o
);

    logic [3:0][7:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic [1:0]         ofs;
    logic [3:0]         lane_we;
    logic [3:0][7:0]    lane_data;
    logic [XLEN-1:0]    rd_word;
    logic [7:0]         rd_byte;
    logic [15:0]        rd_half;
    logic [XLEN-1:0]    load_data;
    logic               misaligned;

    assign idx = addr_i[DMEM_AW+1:2];
    assign ofs = addr_i[1:0];

    // narrow stores replicate the data so that any lane can take it.
    always_comb begin
        lane_we   = 4'b0000;
        lane_data = wdata_i;
        case (op_i)
            MEM_SB: begin
                lane_we   = 4'b0001 << ofs;
                lane_data = {4{wdata_i[7:0]}};
            end
            MEM_SH: begin
                lane_we   = 4'b0011 << {ofs[1], 1'b0};
                lane_data = {2{wdata_i[15:0]}};
            end
            MEM_SW:  lane_we = 4'b1111;
            default: lane_we = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_we[i]) mem[idx][i] <= lane_data[i];
            end
        end
    end

    assign rd_word = mem[idx];
    assign rd_byte = rd_word[ofs*8 +: 8];
    assign rd_half = ofs[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (op_i)
            MEM_LB:  load_data = {{24{rd_byte[7]}}, rd_byte};
            MEM_LBU: load_data = {24'd0, rd_byte};
            MEM_LH:  load_data = {{16{rd_half[15]}}, rd_half};
            MEM_LHU: load_data = {16'd0, rd_half};
            MEM_LW:  load_data = rd_word;
            default: load_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) rdata_o <= '0;
        else          rdata_o <= load_data; // old contents when a store hits the same word.
    end

    always_comb begin
        case (op_i)
            MEM_LH, MEM_LHU, MEM_SH: misaligned = ofs[0];
            MEM_LW, MEM_SW:          misaligned = (ofs != 2'b00);
            default:                 misaligned = 1'b0;
        endcase
    end

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n_i) en_i |-> !misaligned)
        else $error("misaligned data access at %h", addr_i);

endmodule

// File: rtl/csr_file.sv
module csr_file
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            en_i,
    input  csr_op_e         op_i,
    input  logic [11:0]     addr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic            retire_i,
    output logic [XLEN-1:0] rdata_o,
    output logic [XLEN-1:0] instret_o
);

    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] cycle_q;
    logic [XLEN-1:0] instret_q;
    logic [XLEN-1:0] wr_val;
    logic            wr_en;

    always_comb begin
        case (addr_i)
            CSR_MSCRATCH: rdata_o = mscratch_q;
            CSR_CYCLE:    rdata_o = cycle_q;
            CSR_INSTRET:  rdata_o = instret_q;
            default:      rdata_o = '0;
        endcase
    end

    // only mscratch is writable, the counters ignore CSR writes.
    always_comb begin
        case (op_i)
            CSR_RS:  wr_val = mscratch_q | wdata_i;
            CSR_RC:  wr_val = mscratch_q & ~wdata_i;
            default: wr_val = wdata_i;
        endcase
    end

    assign wr_en = en_i && (op_i != CSR_NONE) && (addr_i == CSR_MSCRATCH);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mscratch_q <= '0;
            cycle_q    <= '0;
            instret_q  <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
            if (wr_en)    mscratch_q <= wr_val;
            if (retire_i) instret_q  <= instret_q + 1'b1;
        end
    end

    assign instret_o = instret_q;

    a_instret_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        (instret_q - $past(instret_q)) <= 1)
        else $error("instret jumped from %h to %h", $past(instret_q), instret_q);

endmodule

// File: rtl/register_file.sv
module register_file
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            wen_i,
    input  logic [4:0]      waddr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic [4:0]      raddr_a_i,
    input  logic [4:0]      raddr_b_i,
    output logic [XLEN-1:0] rdata_a_o,
    output logic [XLEN-1:0] rdata_b_o
);

    logic [XLEN-1:0] regs [32];

    // a read of the register being written sees the new value in the same cycle.
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] raddr);
        if (raddr == 5'd0) begin
            return '0;
        end else if (wen_i && (waddr_i == raddr)) begin
            return wdata_i;
        end
        return regs[raddr];
    endfunction

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i; // x0 stays zero.
        end
    end

endmodule

// File: rtl/writeback_stage.sv
module writeback_stage
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  wb_req_t         wb_i,
    input  logic [XLEN-1:0] mem_rdata_i,
    output logic            rf_wen_o,
    output logic [4:0]      rf_waddr_o,
    output logic [XLEN-1:0] rf_wdata_o,
    output logic            retire_o,
    output logic            exit_o
);

    inst_id_t saved_id_q;
    logic     is_new;

    always_comb begin
        case (wb_i.ctrl.wb_sel)
            WB_MEM:  rf_wdata_o = mem_rdata_i;
            WB_PC:   rf_wdata_o = wb_i.pc + XLEN'(4); // link address.
            WB_CSR:  rf_wdata_o = wb_i.csr_rdata;
            default: rf_wdata_o = wb_i.alu_out;
        endcase
    end

    // a stalled instruction is presented again with the same id.
    // only its first valid cycle retires and writes the register file.
    assign is_new = wb_i.valid && (wb_i.inst_id != saved_id_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            saved_id_q <= IID_NONE;
        end else if (wb_i.valid) begin
            saved_id_q <= wb_i.inst_id;
        end
    end

    assign retire_o   = is_new;
    assign rf_wen_o   = is_new && wb_i.ctrl.rf_wen;
    assign rf_waddr_o = wb_i.ctrl.wb_addr;

    assign exit_o = wb_i.valid && (wb_i.pc == EXIT_PC);

    a_retire_once: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_o && $past(retire_o) |-> wb_i.inst_id != $past(wb_i.inst_id))
        else $error("id %h retired twice", wb_i.inst_id);

endmodule

// File: rtl/pipe_backend.sv
module pipe_backend
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  mem_req_t        req_i,
    input  logic [4:0]      rd_addr_a_i,
    input  logic [4:0]      rd_addr_b_i,
    output logic [XLEN-1:0] rd_data_a_o,
    output logic [XLEN-1:0] rd_data_b_o,
    output logic [XLEN-1:0] wb_wdata_o,
    output logic [XLEN-1:0] retired_o,
    output logic            exit_o
);

    inst_id_t        mem_id_q;
    logic            mem_new;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] instret;
    wb_req_t         wb_q;
    logic            rf_wen;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;
    logic            retire;

    // stores and CSR writes take effect on the first valid cycle of an id only.
    assign mem_new = req_i.valid && (req_i.inst_id != mem_id_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_id_q <= IID_NONE;
            wb_q     <= '0;
        end else begin
            if (req_i.valid) mem_id_q <= req_i.inst_id;
            wb_q.valid     <= req_i.valid;
            wb_q.pc        <= req_i.pc;
            wb_q.inst_id   <= req_i.inst_id;
            wb_q.ctrl      <= req_i.ctrl;
            wb_q.alu_out   <= req_i.alu_out;
            wb_q.csr_rdata <= csr_rdata; // old CSR value, read before this edge writes it.
        end
    end

    data_memory u_dmem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (mem_new),
        .op_i    (req_i.ctrl.mem_op),
        .addr_i  (req_i.alu_out),
        .wdata_i (req_i.operand),
        .rdata_o (mem_rdata)
    );

    csr_file u_csr (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .en_i      (mem_new),
        .op_i      (req_i.ctrl.csr_op),
        .addr_i    (req_i.ctrl.csr_addr),
        .wdata_i   (req_i.operand),
        .retire_i  (retire),
        .rdata_o   (csr_rdata),
        .instret_o (instret)
    );

    writeback_stage u_wb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_i        (wb_q),
        .mem_rdata_i (mem_rdata),
        .rf_wen_o    (rf_wen),
        .rf_waddr_o  (rf_waddr),
        .rf_wdata_o  (rf_wdata),
        .retire_o    (retire),
        .exit_o      (exit_o)
    );

    register_file u_rf (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wen_i     (rf_wen),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rd_addr_a_i),
        .raddr_b_i (rd_addr_b_i),
        .rdata_a_o (rd_data_a_o),
        .rdata_b_o (rd_data_b_o)
    );

    assign wb_wdata_o = rf_wdata;
    assign retired_o  = instret;

endmodule

// File: tests/tb_backend.sv
module tb_backend
    import core_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int EST_CYCLES = 100; // reset plus every stimulus cycle, rounded up.
    localparam int MAX_CYCLES = 4 * EST_CYCLES;

    logic            clk = 1'b0;
    logic            rst_n;
    mem_req_t        req;
    logic [4:0]      rd_addr_a, rd_addr_b;
    logic [XLEN-1:0] rd_data_a, rd_data_b, wb_wdata, retired;
    logic            exit_flag;

    // expected results of the instruction being driven, delayed to its write-back cycle.
    logic            issue_chk, issue_wen, issue_new, issue_exit;
    logic [4:0]      issue_rd;
    logic [XLEN-1:0] issue_data;
    logic            chk_q, new_q, exit_q;
    logic [XLEN-1:0] chk_data_q;

    logic [XLEN-1:0] model_rf [32];
    logic [7:0]      model_mem [DMEM_WORDS*4];
    logic [XLEN-1:0] model_mscratch, model_retired;
    logic [31:0]     rng;
    inst_id_t        next_id;
    logic [XLEN-1:0] pc_next;
    int              n_issued, errors, cycles;

    pipe_backend uut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .wb_wdata_o  (wb_wdata),
        .retired_o   (retired),
        .exit_o      (exit_flag)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        chk_q      <= issue_chk;
        chk_data_q <= issue_data;
        exit_q     <= issue_exit;
        new_q      <= issue_new;
        if (new_q) model_retired <= model_retired + 1'b1; // counted when the pulse ends.
        if (issue_wen) model_rf[issue_rd] <= issue_data;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: exit_o did not rise within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        chk_q |-> wb_wdata == chk_data_q)
        else begin
            errors++;
            $display("Fail wb_wdata_o: got %h, expected %h", $sampled(wb_wdata),
                     $sampled(chk_data_q));
        end

    a_port_a: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_a == model_rf[rd_addr_a])
        else begin
            errors++;
            $display("Fail rd_data_a_o: got %h, expected %h", $sampled(rd_data_a),
                     $sampled(model_rf[rd_addr_a]));
        end

    a_port_b: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_b == model_rf[rd_addr_b])
        else begin
            errors++;
            $display("Fail rd_data_b_o: got %h, expected %h", $sampled(rd_data_b),
                     $sampled(model_rf[rd_addr_b]));
        end

    a_retired: assert property (@(posedge clk) disable iff (!rst_n) retired == model_retired)
        else begin
            errors++;
            $display("Fail retired_o: got %h, expected %h", $sampled(retired),
                     $sampled(model_retired));
        end

    a_exit: assert property (@(posedge clk) disable iff (!rst_n) exit_flag == exit_q)
        else begin
            errors++;
            $display("Fail exit_o: got %h, expected %h", $sampled(exit_flag), $sampled(exit_q));
        end

    function automatic logic [31:0] random_word();
        logic [31:0] x;
        x = rng;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng = x;
        return x;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = random_word();
        return 5'(r % 31) + 5'd1; // x1 to x31.
    endfunction

    function automatic ctrl_t make_ctrl(input wb_sel_e sel, input logic wen, input logic [4:0] rd,
                                        input mem_op_e mop, input csr_op_e cop,
                                        input logic [11:0] caddr);
        ctrl_t c;
        c.wb_sel   = sel;
        c.rf_wen   = wen;
        c.wb_addr  = rd;
        c.mem_op   = mop;
        c.csr_op   = cop;
        c.csr_addr = caddr;
        return c;
    endfunction

    // load value built from the byte model, little endian.
    function automatic logic [XLEN-1:0] expect_load(input mem_op_e op, input logic [XLEN-1:0] addr);
        logic [9:0] a;
        logic [7:0] b0, b1;
        a  = addr[9:0];
        b0 = model_mem[a];
        b1 = model_mem[a + 10'd1];
        case (op)
            MEM_LB:  return {{24{b0[7]}}, b0};
            MEM_LBU: return {24'd0, b0};
            MEM_LH:  return {{16{b1[7]}}, b1, b0};
            MEM_LHU: return {16'd0, b1, b0};
            default: return {model_mem[a + 10'd3], model_mem[a + 10'd2], b1, b0};
        endcase
    endfunction

    task automatic write_bytes(input mem_op_e op, input logic [XLEN-1:0] addr,
                               input logic [XLEN-1:0] data);
        int n;
        n = (op == MEM_SB) ? 1 : ((op == MEM_SH) ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            model_mem[addr[9:0] + 10'(i)] = data[8*i +: 8];
        end
    endtask

    // one instruction, presented for a number of cycles with the same id.
    task automatic send(input ctrl_t c, input logic [XLEN-1:0] alu, input logic [XLEN-1:0] opnd,
                        input logic [XLEN-1:0] exp_data, input int repeats);
        inst_id_t id;
        id      = next_id;
        next_id = (next_id == IID_NONE - 1) ? '0 : next_id + 1'b1;
        for (int r = 0; r < repeats; r++) begin
            @(posedge clk);
            #1;
            req.valid   = 1'b1;
            req.pc      = pc_next;
            req.inst_id = id;
            req.ctrl    = c;
            req.alu_out = alu;
            req.operand = opnd;
            issue_chk   = 1'b1;
            issue_data  = exp_data;
            issue_rd    = c.wb_addr;
            issue_wen   = (r == 0) && c.rf_wen && (c.wb_addr != 5'd0);
            issue_new   = (r == 0);
            issue_exit  = (pc_next == EXIT_PC);
        end
        pc_next = pc_next + 32'd4;
        n_issued++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        req.valid = 1'b0;
        {issue_chk, issue_wen, issue_new, issue_exit} = '0;
    endtask

    task automatic store(input mem_op_e op, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] data, input int repeats);
        write_bytes(op, addr, data);
        send(make_ctrl(WB_ALU, 1'b0, 5'd0, op, CSR_NONE, 12'h0), addr, data, addr, repeats);
    endtask

    task automatic load(input mem_op_e op, input logic [XLEN-1:0] addr);
        logic [4:0] rd;
        rd        = pick_reg();
        rd_addr_a = rd;
        send(make_ctrl(WB_MEM, 1'b1, rd, op, CSR_NONE, 12'h0), addr, 32'h0,
             expect_load(op, addr), 1);
    endtask

    task automatic csr_access(input csr_op_e op, input logic [XLEN-1:0] operand);
        logic [XLEN-1:0] old;
        old = model_mscratch;
        send(make_ctrl(WB_CSR, 1'b1, pick_reg(), MEM_NONE, op, CSR_MSCRATCH), 32'h0, operand,
             old, 1);
        case (op)
            CSR_RW:  model_mscratch = operand;
            CSR_RS:  model_mscratch = old | operand;
            default: model_mscratch = old & ~operand;
        endcase
        send(make_ctrl(WB_CSR, 1'b1, pick_reg(), MEM_NONE, CSR_RS, CSR_MSCRATCH), 32'h0, 32'h0,
             model_mscratch, 1); // a set with zero only reads back.
    endtask

    initial begin
        logic [4:0]      rd;
        logic [XLEN-1:0] v, a, ah, ab;
        rst_n          = 1'b0;
        req            = '0;
        rd_addr_a      = '0;
        rd_addr_b      = '0;
        issue_rd       = '0;
        issue_data     = '0;
        {issue_chk, issue_wen, issue_new, issue_exit} = '0;
        model_retired  = '0;
        model_mscratch = '0;
        rng            = 32'h47c3_0e6b;
        next_id        = '0;
        pc_next        = 32'h0000_0100;
        for (int i = 0; i < 32; i++) model_rf[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // port A follows each written register, through the bypass and then from storage.
        for (int i = 0; i < 8; i++) begin
            rd        = pick_reg();
            v         = random_word();
            rd_addr_b = pick_reg();
            send(make_ctrl(WB_ALU, 1'b1, rd, MEM_NONE, CSR_NONE, 12'h0), v, 32'h0, v, 1);
            rd_addr_a = rd;
            idle_cycle();
            if (i % 2 == 1) idle_cycle();
        end
        rd_addr_b = 5'd0;
        v = random_word();
        send(make_ctrl(WB_ALU, 1'b1, 5'd0, MEM_NONE, CSR_NONE, 12'h0), v, 32'h0, v, 1);
        idle_cycle();

        for (int i = 0; i < 4; i++) begin
            v  = random_word();
            a  = {22'd0, v[7:0], 2'b00};
            ah = a + {30'd0, v[8], 1'b0};
            ab = a + {30'd0, v[10:9]};
            store(MEM_SW, a, random_word(), 1);
            load(MEM_LW, a); // right behind the store to the same word.
            store(MEM_SH, ah, random_word(), 1);
            store(MEM_SB, ab, random_word(), 1);
            load(MEM_LH, ah);
            load(MEM_LHU, ah);
            load(MEM_LB, ab);
            load(MEM_LBU, ab);
            load(MEM_LW, a);
        end

        rd        = pick_reg();
        rd_addr_a = rd;
        send(make_ctrl(WB_PC, 1'b1, rd, MEM_NONE, CSR_NONE, 12'h0), 32'h0, 32'h0,
             pc_next + 32'd4, 1);
        csr_access(CSR_RW, random_word());
        csr_access(CSR_RS, random_word());
        csr_access(CSR_RC, random_word());

        rd        = pick_reg();
        v         = random_word();
        rd_addr_a = rd;
        send(make_ctrl(WB_ALU, 1'b1, rd, MEM_NONE, CSR_NONE, 12'h0), v, 32'h0, v, 3);
        v = random_word();
        a = {22'd0, v[7:0], 2'b00};
        store(MEM_SW, a, random_word(), 3);
        load(MEM_LW, a);
        idle_cycle();
        // every earlier id has retired by now.
        send(make_ctrl(WB_CSR, 1'b1, pick_reg(), MEM_NONE, CSR_RS, CSR_INSTRET), 32'h0, 32'h0,
             n_issued, 1);

        idle_cycle();
        pc_next = EXIT_PC;
        send(make_ctrl(WB_ALU, 1'b0, 5'd0, MEM_NONE, CSR_NONE, 12'h0), 32'h0, 32'h0, 32'h0, 1);
        idle_cycle();
        while (exit_flag !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        $display("errors: %0d, instructions issued: %0d", errors, n_issued);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/core_pkg.sv
rtl/data_memory.sv
rtl/csr_file.sv
rtl/register_file.sv
rtl/writeback_stage.sv
rtl/pipe_backend.sv
tests/tb_backend.sv
